// File: files.f
source/emesh_pkg.sv
source/etx_pkg.sv
source/emesh_unpack.sv
source/etx_sequencer.sv
source/etx_word_mux.sv
source/etx_io.sv
sim/etx_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the etx_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

# Compile packages, RTL and testbench from the file list
verilator --binary --timing --assert \
   --top-module etx_io_tb \
   --Mdir "$build_dir" \
   -o etx_io_tb \
   -f files.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Run the simulation, keep a log for the result search
"./$build_dir/etx_io_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q '\*\* FAIL \*\*' "$log_file"; then
   exit 1
fi
exit 0

// File: sim/etx_io_tb.sv
`timescale 1ns/100ps

module etx_io_tb;

   localparam int timeout_cycles = 2000;

   // DUT inputs
   logic               tx_lclk;
   logic               reset;
   emesh_pkg::packet_t tx_packet;
   logic               tx_access;
   logic               tx_burst;
   logic               txi_wr_wait;
   logic               txi_rd_wait;

   // DUT outputs
   etx_pkg::word_t     txo_data;
   logic               txo_frame;
   logic               tx_io_wait;
   logic               tx_wr_wait;
   logic               tx_rd_wait;

   integer             seed = 32'h9b5570cf;
   int                 errors;
   int                 checks;
   int                 cycles;

   // Framed words seen on the link and words the model predicts
   etx_pkg::word_t     capture [$];
   etx_pkg::word_t     expected [$];
   etx_pkg::word_t     model_words [7];

   etx_io i_etx_io (
      .tx_lclk     (tx_lclk),
      .reset       (reset),
      .tx_packet   (tx_packet),
      .tx_access   (tx_access),
      .tx_burst    (tx_burst),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .txo_data    (txo_data),
      .txo_frame   (txo_frame),
      .tx_io_wait  (tx_io_wait),
      .tx_wr_wait  (tx_wr_wait),
      .tx_rd_wait  (tx_rd_wait)
   );

   // 40 ns link clock
   always #20 tx_lclk = ~tx_lclk;

   // Framed word capture on the falling edge
   always @(negedge tx_lclk)
   begin
      if (!reset && txo_frame)
         capture.push_back(txo_data);
   end

   // Run limit
   always @(posedge tx_lclk)
   begin
      cycles++;
      if (cycles >= timeout_cycles)
      begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   // ##################################################
   // Checking and reference model
   // ##################################################
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      end
   endtask

   // Seven link words from raw packet bits
   task automatic build_words(input emesh_pkg::packet_t p);
      // Read flag, ctrlmode, top nibble of dstaddr
      model_words[0] = {~p[1], 7'b0, p[7:4], p[39:36]};
      model_words[1] = p[35:20];
      // Low dstaddr, datamode, write, access
      model_words[2] = {p[19:8], p[3:2], p[1], p[0]};
      model_words[3] = p[71:56];
      model_words[4] = p[55:40];
      model_words[5] = p[103:88];
      model_words[6] = p[87:72];
   endtask

   task automatic expect_words(input emesh_pkg::packet_t p, input int first);
      build_words(p);
      for (int k = first; k < 7; k++)
         expected.push_back(model_words[k]);
   endtask

   function automatic emesh_pkg::packet_t random_packet(input logic wr);
      logic [127:0]       raw;
      emesh_pkg::packet_t p;
      raw  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      p    = raw[103:0];
      p[1] = wr;
      p[0] = 1'b1;
      return p;
   endfunction

   task automatic start_capture();
      capture.delete();
      expected.delete();
   endtask

   task automatic compare_stream();
      check_value("capture length", 32'(capture.size()), 32'(expected.size()));
      for (int i = 0; i < capture.size() && i < expected.size(); i++)
         check_value($sformatf("txo_data[%0d]", i), 32'(capture[i]), 32'(expected[i]));
   endtask

   // ##################################################
   // Fabric side drivers
   // ##################################################
   // Hold the packet until tx_io_wait drops and count the cycles waited
   task automatic send_packet(input emesh_pkg::packet_t p, input logic burst,
                              output int waits);
      tx_packet = p;
      tx_access = 1'b1;
      tx_burst  = burst;
      @(negedge tx_lclk);
      waits = 1;
      while (tx_io_wait && waits < 20)
      begin
         @(negedge tx_lclk);
         waits++;
      end
      if (tx_io_wait)
      begin
         errors++;
         $display("Packet was never accepted, tx_io_wait stayed high");
      end
      // Accepting edge
      @(negedge tx_lclk);
   endtask

   // Fabric goes idle and the frame must close
   task automatic end_traffic();
      int n;
      tx_access = 1'b0;
      tx_burst  = 1'b0;
      n = 0;
      while (txo_frame && n < 12)
      begin
         @(negedge tx_lclk);
         n++;
      end
      if (txo_frame)
      begin
         errors++;
         $display("Frame did not drop after the last packet");
      end
      check_value("txo_data idle", 32'(txo_data), 32'h0);
   endtask

   // ##################################################
   // Directed tests
   // ##################################################
   task automatic reset_test();
      logic [31:0] rnd;
      for (int n = 0; n < 16; n++)
      begin
         @(negedge tx_lclk);
         check_value("txo_frame", 32'(txo_frame), 32'h0);
         check_value("txo_data", 32'(txo_data), 32'h0);
         check_value("tx_wr_wait", 32'(tx_wr_wait), 32'h0);
         check_value("tx_rd_wait", 32'(tx_rd_wait), 32'h0);
         check_value("tx_io_wait", 32'(tx_io_wait), 32'(tx_access));
         rnd         = $random(seed);
         tx_access   = rnd[0];
         txi_wr_wait = rnd[1];
         txi_rd_wait = rnd[2];
      end
      reset       = 1'b0;
      tx_access   = 1'b0;
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      // Idle link after release
      repeat (4)
      begin
         @(negedge tx_lclk);
         check_value("txo_frame", 32'(txo_frame), 32'h0);
         check_value("txo_data", 32'(txo_data), 32'h0);
         check_value("tx_wr_wait", 32'(tx_wr_wait), 32'h0);
         check_value("tx_rd_wait", 32'(tx_rd_wait), 32'h0);
         check_value("tx_io_wait", 32'(tx_io_wait), 32'h0);
      end
   endtask

   task automatic single_write_test();
      emesh_pkg::packet_t p;
      int                 waits;
      p = random_packet(1'b1);
      start_capture();
      expect_words(p, 0);
      expected.push_back(16'h0);
      send_packet(p, 1'b0, waits);
      check_value("tx_io_wait cycles", 32'(waits), 32'd6);
      end_traffic();
      compare_stream();
   endtask

   task automatic read_packet_test();
      emesh_pkg::packet_t p;
      int                 waits;
      p = random_packet(1'b0);
      start_capture();
      expect_words(p, 0);
      expected.push_back(16'h0);
      send_packet(p, 1'b0, waits);
      end_traffic();
      compare_stream();
      if (capture.size() < 3)
      begin
         errors++;
         $display("Read packet produced fewer than three framed words");
      end
      else
      begin
         check_value("word 0 read flag", 32'(capture[0][15]), 32'h1);
         check_value("word 2 mode bits", 32'(capture[2][3:0]), 32'({p[3:2], 2'b01}));
      end
   endtask

   // Later packets only resend data and source address
   task automatic burst_test();
      emesh_pkg::packet_t p;
      int                 waits;
      start_capture();
      for (int i = 0; i < 3; i++)
      begin
         p = random_packet(1'b1);
         expect_words(p, (i == 0) ? 0 : etx_pkg::burst_restart_slot);
         send_packet(p, (i < 2), waits);
         check_value("burst wait cycles", 32'(waits), (i == 0) ? 32'd6 : 32'd3);
      end
      expected.push_back(16'h0);
      end_traffic();
      compare_stream();
   endtask

   // Back-to-back packets each replaced only after tx_io_wait low
   task automatic back_to_back_test();
      emesh_pkg::packet_t p;
      int                 waits;
      logic [31:0]        rnd;
      start_capture();
      for (int i = 0; i < 3; i++)
      begin
         rnd = $random(seed);
         p   = random_packet(rnd[0]);
         expect_words(p, 0);
         expected.push_back(16'h0);
         send_packet(p, 1'b0, waits);
         check_value("packet wait cycles", 32'(waits), (i == 0) ? 32'd6 : 32'd7);
      end
      end_traffic();
      compare_stream();
   endtask

   task automatic pushback_test();
      logic [31:0] rnd;
      logic        wr_d1;
      logic        wr_d2;
      logic        rd_d1;
      logic        rd_d2;
      wr_d1 = 1'b0;
      wr_d2 = 1'b0;
      rd_d1 = 1'b0;
      rd_d2 = 1'b0;
      for (int n = 0; n < 40; n++)
      begin
         @(negedge tx_lclk);
         // Output shows what was driven two edges back
         check_value("tx_wr_wait", 32'(tx_wr_wait), 32'(wr_d2));
         check_value("tx_rd_wait", 32'(tx_rd_wait), 32'(rd_d2));
         rnd         = $random(seed);
         wr_d2       = wr_d1;
         rd_d2       = rd_d1;
         wr_d1       = rnd[0];
         rd_d1       = rnd[1];
         txi_wr_wait = wr_d1;
         txi_rd_wait = rd_d1;
      end
      @(negedge tx_lclk);
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
   endtask

   // ##################################################
   // Main sequence
   // ##################################################
   initial
   begin
      tx_lclk     = 1'b0;
      reset       = 1'b1;
      tx_packet   = '0;
      tx_access   = 1'b0;
      tx_burst    = 1'b0;
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      reset_test();
      single_write_test();
      read_packet_test();
      burst_test();
      back_to_back_test();
      pushback_test();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: source/etx_io.sv
`timescale 1ns/100ps

module etx_io (
   input  logic               tx_lclk,
   input  logic               reset,
   input  emesh_pkg::packet_t tx_packet,
   input  logic               tx_access,
   input  logic               tx_burst,
   input  logic               txi_wr_wait,
   input  logic               txi_rd_wait,
   output etx_pkg::word_t     txo_data,
   output logic               txo_frame,
   output logic               tx_io_wait,
   output logic               tx_wr_wait,
   output logic               tx_rd_wait
);

   // Packet fields
   logic                 access;
   logic                 write;
   emesh_pkg::datamode_t datamode;
   emesh_pkg::ctrlmode_t ctrlmode;
   emesh_pkg::addr_t     dstaddr;
   emesh_pkg::data_t     data;
   emesh_pkg::addr_t     srcaddr;

   // Slot select from sequencer
   etx_pkg::word_sel_t   word_sel;

   // ##################################################
   // Packet split, sequencer, word register
   // ##################################################
   emesh_unpack i_emesh_unpack (
      .packet      (tx_packet),
      .access      (access),
      .write       (write),
      .datamode    (datamode),
      .ctrlmode    (ctrlmode),
      .dstaddr     (dstaddr),
      .data        (data),
      .srcaddr     (srcaddr)
   );

   etx_sequencer i_etx_sequencer (
      .tx_lclk     (tx_lclk),
      .reset       (reset),
      .tx_access   (tx_access),
      .tx_burst    (tx_burst),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .word_sel    (word_sel),
      .txo_frame   (txo_frame),
      .tx_io_wait  (tx_io_wait),
      .tx_wr_wait  (tx_wr_wait),
      .tx_rd_wait  (tx_rd_wait)
   );

   etx_word_mux i_etx_word_mux (
      .tx_lclk     (tx_lclk),
      .reset       (reset),
      .word_sel    (word_sel),
      .write       (write),
      .access      (access),
      .datamode    (datamode),
      .ctrlmode    (ctrlmode),
      .dstaddr     (dstaddr),
      .data        (data),
      .srcaddr     (srcaddr),
      .txo_data    (txo_data)
   );

endmodule

// File: source/etx_word_mux.sv
`timescale 1ns/100ps

module etx_word_mux (
   input  logic                 tx_lclk,
   input  logic                 reset,
   input  etx_pkg::word_sel_t   word_sel,
   input  logic                 write,
   input  logic                 access,
   input  emesh_pkg::datamode_t datamode,
   input  emesh_pkg::ctrlmode_t ctrlmode,
   input  emesh_pkg::addr_t     dstaddr,
   input  emesh_pkg::data_t     data,
   input  emesh_pkg::addr_t     srcaddr,
   output etx_pkg::word_t       txo_data
);

   // ##################################################
   // Link word per slot
   // ##################################################
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
         txo_data <= '0;
      else
      begin
         case (word_sel)
            // Header, read flag on top
            7'b0000001:
               txo_data <= {~write, 7'b0, ctrlmode, dstaddr[31:28]};
            7'b0000010:
               txo_data <= dstaddr[27:12];
            7'b0000100:
               txo_data <= {dstaddr[11:0], datamode, write, access};
            // Data
            7'b0001000:
               txo_data <= data[31:16];
            7'b0010000:
               txo_data <= data[15:0];
            // Source address, return path for reads
            7'b0100000:
               txo_data <= srcaddr[31:16];
            7'b1000000:
               txo_data <= srcaddr[15:0];
            // Gap slot or idle fabric
            default:
               txo_data <= '0;
         endcase
      end
   end

   // Sequencer never selects two slots at once
   a_sel_onehot0: assert property (@(posedge tx_lclk) disable iff (reset)
      $onehot0(word_sel));

endmodule

// File: source/etx_sequencer.sv
`timescale 1ns/100ps

module etx_sequencer (
   input  logic               tx_lclk,
   input  logic               reset,
   input  logic               tx_access,
   input  logic               tx_burst,
   input  logic               txi_wr_wait,
   input  logic               txi_rd_wait,
   output etx_pkg::word_sel_t word_sel,
   output logic               txo_frame,
   output logic               tx_io_wait,
   output logic               tx_wr_wait,
   output logic               tx_rd_wait
);

   etx_pkg::pointer_t   pointer;
   etx_pkg::seq_state_t state;
   etx_pkg::seq_state_t state_next;
   logic [1:0]          wait_sync [etx_pkg::sync_stages];

   // ##################################################
   // Slot pointer
   // ##################################################
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
         pointer <= etx_pkg::pointer_t'(1);
      else if (!tx_access)
         pointer <= etx_pkg::pointer_t'(1);
      // Burst skips header, goes back to data slot
      else if (pointer[6] && tx_burst)
         pointer <= etx_pkg::pointer_t'(1) << etx_pkg::burst_restart_slot;
      else
         pointer <= {pointer[6:0], pointer[7]};
   end

   // Slot bits only while fabric is driving
   assign word_sel   = pointer[6:0] & {$bits(etx_pkg::word_sel_t){tx_access}};

   // Packet consumed at last word slot
   assign tx_io_wait = tx_access & ~pointer[6];

   // ##################################################
   // Frame FSM, one cycle behind the pointer
   // ##################################################
   always_comb
   begin
      state_next = state;
      case (state)
         etx_pkg::seq_idle:
            if (tx_access && pointer[0])
               state_next = etx_pkg::seq_header;
         etx_pkg::seq_header:
            // Header words 0..2, abort closes the frame
            if (!tx_access)
               state_next = etx_pkg::seq_gap;
            else if (pointer[3])
               state_next = etx_pkg::seq_payload;
         etx_pkg::seq_payload:
            // Only reached via slot 7 when burst was low at slot 6
            if (pointer[7] || !tx_access)
               state_next = etx_pkg::seq_gap;
         etx_pkg::seq_gap:
            // Back-to-back packet keeps the frame up
            if (tx_access && pointer[0])
               state_next = etx_pkg::seq_header;
            else
               state_next = etx_pkg::seq_idle;
         default:
            state_next = etx_pkg::seq_idle;
      endcase
   end

   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         state     <= etx_pkg::seq_idle;
         txo_frame <= 1'b0;
      end
      else
      begin
         state     <= state_next;
         // Frame covers every non-idle word, including the gap word
         txo_frame <= (state_next != etx_pkg::seq_idle);
      end
   end

   // ##################################################
   // Pushback synchronizers
   // ##################################################
   always_ff @(posedge tx_lclk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < etx_pkg::sync_stages; i++)
            wait_sync[i] <= '0;
      end
      else
      begin
         wait_sync[0] <= {txi_rd_wait, txi_wr_wait};
         for (int i = 1; i < etx_pkg::sync_stages; i++)
            wait_sync[i] <= wait_sync[i-1];
      end
   end

   assign tx_wr_wait = wait_sync[etx_pkg::sync_stages-1][0];
   assign tx_rd_wait = wait_sync[etx_pkg::sync_stages-1][1];

   // Pointer stays one-hot across burst jumps
   a_pointer_onehot: assert property (@(posedge tx_lclk) disable iff (reset)
      $onehot(pointer));

   // Frame only opens for a packet the fabric offered
   a_frame_rise: assert property (@(posedge tx_lclk) disable iff (reset)
      $rose(txo_frame) |-> $past(tx_access));

endmodule

// File: source/emesh_unpack.sv
`timescale 1ns/100ps

module emesh_unpack (
   input  emesh_pkg::packet_t   packet,
   output logic                 access,
   output logic                 write,
   output emesh_pkg::datamode_t datamode,
   output emesh_pkg::ctrlmode_t ctrlmode,
   output emesh_pkg::addr_t     dstaddr,
   output emesh_pkg::data_t     data,
   output emesh_pkg::addr_t     srcaddr
);

   // Control bits
   assign access   = packet[emesh_pkg::access_lsb];
   assign write    = packet[emesh_pkg::write_lsb];
   assign datamode = packet[emesh_pkg::datamode_lsb +: emesh_pkg::datamode_width];
   assign ctrlmode = packet[emesh_pkg::ctrlmode_lsb +: emesh_pkg::ctrlmode_width];

   // Address and data words
   assign dstaddr  = packet[emesh_pkg::dstaddr_lsb +: emesh_pkg::addr_width];
   assign data     = packet[emesh_pkg::data_lsb +: emesh_pkg::data_width];
   assign srcaddr  = packet[emesh_pkg::srcaddr_lsb +: emesh_pkg::addr_width];

   // Fields must tile the packet with no hole and no overlap
   initial
   begin
      assert ((emesh_pkg::write_lsb == emesh_pkg::access_lsb + 1) &&
              (emesh_pkg::datamode_lsb == emesh_pkg::write_lsb + 1) &&
              (emesh_pkg::ctrlmode_lsb == emesh_pkg::datamode_lsb + emesh_pkg::datamode_width) &&
              (emesh_pkg::dstaddr_lsb == emesh_pkg::ctrlmode_lsb + emesh_pkg::ctrlmode_width) &&
              (emesh_pkg::data_lsb == emesh_pkg::dstaddr_lsb + emesh_pkg::addr_width) &&
              (emesh_pkg::srcaddr_lsb == emesh_pkg::data_lsb + emesh_pkg::data_width) &&
              (emesh_pkg::packet_width == emesh_pkg::srcaddr_lsb + emesh_pkg::addr_width))
      else
         $error("emesh packet fields do not tile packet_width");
   end

endmodule

// File: source/etx_pkg.sv
package etx_pkg;

   // ##################################################
   // Link side of the transmitter
   // ##################################################

   // One link word per tx_lclk, high byte is first DDR edge
   typedef logic [15:0] word_t;

   // One-hot slot pointer, bits 0..6 word slots, bit 7 gap slot
   typedef logic [7:0]  pointer_t;

   // Word slots only, zero when fabric idle
   typedef logic [6:0]  word_sel_t;

   // Phase of the word currently on the link
   typedef enum logic [1:0] {
      seq_idle,
      seq_header,
      seq_payload,
      seq_gap
   } seq_state_t;

   // Burst continuation re-enters at the data words
   localparam int burst_restart_slot = 3;

   // Pushback synchronizer depth
   localparam int sync_stages = 2;

endpackage

// File: source/emesh_pkg.sv
package emesh_pkg;

   // ##################################################
   // Packet format, fixed at 104 bits
   // ##################################################
   localparam int packet_width   = 104;

   // Field widths
   localparam int addr_width     = 32;
   localparam int data_width     = 32;
   localparam int ctrlmode_width = 4;
   localparam int datamode_width = 2;

   // Lowest bit of each field
   localparam int access_lsb     = 0;
   localparam int write_lsb      = 1;
   localparam int datamode_lsb   = 2;
   localparam int ctrlmode_lsb   = 4;
   localparam int dstaddr_lsb    = 8;
   localparam int data_lsb       = 40;
   localparam int srcaddr_lsb    = 72;

   // Field types
   typedef logic [packet_width-1:0]   packet_t;
   typedef logic [addr_width-1:0]     addr_t;
   typedef logic [data_width-1:0]     data_t;
   typedef logic [ctrlmode_width-1:0] ctrlmode_t;
   typedef logic [datamode_width-1:0] datamode_t;

endpackage
